//--- rtl/CpuPkg.sv
package CpuPkg;

    // --------------------------------------
    // Major opcodes
    // --------------------------------------
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLui    = 7'b0110111,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111
    } Opcode;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSltu, AluPassB
    } AluOp;

    // --------------------------------------
    // Instruction formats
    // --------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } InstR;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } InstI;

    typedef struct packed {
        logic [6:0] immHi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo; // imm[4:0]
        logic [6:0] opcode;
    } InstS;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi; // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo; // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } InstB;

    typedef struct packed {
        logic [19:0] imm; // Upper 20 bits
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } InstU;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;  // imm[10:1]
        logic       imm11;
        logic [7:0] immMid; // imm[19:12]
        logic [4:0] rd;
        logic [6:0] opcode;
    } InstJ;

    // One fetched word, six views
    typedef union packed {
        InstR r;
        InstI i;
        InstS s;
        InstB b;
        InstU u;
        InstJ j;
    } Inst;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm; // Sign extended
    } DecodedInst;

    // --------------------------------------
    // Datapath selects and buses
    // --------------------------------------
    typedef enum logic [1:0] {OpASelReg, OpASelPc, OpASelZero} OperandASel;
    typedef enum logic {OpBSelReg, OpBSelImm} OperandBSel;
    typedef enum logic [1:0] {WbSelAlu, WbSelMem, WbSelPc4} WbSel;
    typedef enum logic [1:0] {PcSelNext, PcSelBranch, PcSelJalr} PcSel;

    typedef struct packed {
        AluOp       aluOp;
        OperandASel operandASel;
        OperandBSel operandBSel;
        WbSel       wbSel;
        PcSel       pcSel;
        logic       regWrEnable;
        logic       memWrEnable;
    } DatapathCtrl;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrData;
        logic        wrEnable;
    } DataBusReq;

endpackage

//--- rtl/InstDecoder.sv
`timescale 1ns/1ns

module InstDecoder (
    input  CpuPkg::Inst        i_Inst,    // Fetched word
    output CpuPkg::DecodedInst o_Decoded  // Register indices and immediate
);

    // Register fields sit at the same bits in every format
    assign o_Decoded.rs1 = i_Inst.r.rs1;
    assign o_Decoded.rs2 = i_Inst.r.rs2;
    assign o_Decoded.rd  = i_Inst.r.rd;

    always_comb begin
        case (CpuPkg::Opcode'(i_Inst.r.opcode))
            // --------------------------------------
            // I format
            // --------------------------------------
            CpuPkg::OpImm, CpuPkg::OpLoad, CpuPkg::OpJalr: begin
                o_Decoded.imm = {{20{i_Inst.i.imm[11]}}, i_Inst.i.imm};
            end
            // --------------------------------------
            // S format
            // --------------------------------------
            CpuPkg::OpStore: begin
                o_Decoded.imm = {{20{i_Inst.s.immHi[6]}}, i_Inst.s.immHi, i_Inst.s.immLo};
            end
            // --------------------------------------
            // B format
            // --------------------------------------
            CpuPkg::OpBranch: begin
                o_Decoded.imm = {{19{i_Inst.b.imm12}}, i_Inst.b.imm12, i_Inst.b.imm11,
                                 i_Inst.b.immHi, i_Inst.b.immLo, 1'b0}; // Halfword offset
            end
            // --------------------------------------
            // U format
            // --------------------------------------
            CpuPkg::OpLui: begin
                o_Decoded.imm = {i_Inst.u.imm, 12'd0}; // Low bits cleared
            end
            // --------------------------------------
            // J format
            // --------------------------------------
            CpuPkg::OpJal: begin
                o_Decoded.imm = {{11{i_Inst.j.imm20}}, i_Inst.j.imm20, i_Inst.j.immMid,
                                 i_Inst.j.imm11, i_Inst.j.immLo, 1'b0};
            end
            default: o_Decoded.imm = 32'd0; // R format and unknown
        endcase
    end

endmodule

//--- rtl/DatapathController.sv
`timescale 1ns/1ns

module DatapathController (
    input  CpuPkg::Inst         i_Inst,
    input  logic                i_IsEq,  // rs1 == rs2
    input  logic                i_IsLt,  // Signed rs1 < rs2
    input  logic                i_IsLtu, // Unsigned rs1 < rs2
    output CpuPkg::DatapathCtrl o_Ctrl
);

    logic [2:0] funct3;
    logic       isAlt;   // funct7 bit 5 picks SUB
    logic       taken;   // Branch condition met

    assign funct3 = i_Inst.r.funct3;
    assign isAlt  = i_Inst.r.funct7[5];

    // Branch resolution
    always_comb begin
        case (funct3)
            3'b000:  taken = i_IsEq;   // BEQ
            3'b001:  taken = !i_IsEq;  // BNE
            3'b100:  taken = i_IsLt;   // BLT
            3'b101:  taken = !i_IsLt;  // BGE
            3'b110:  taken = i_IsLtu;  // BLTU
            3'b111:  taken = !i_IsLtu; // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        // Defaults give a no-op
        o_Ctrl.aluOp       = CpuPkg::AluAdd;
        o_Ctrl.operandASel = CpuPkg::OpASelReg;
        o_Ctrl.operandBSel = CpuPkg::OpBSelReg;
        o_Ctrl.wbSel       = CpuPkg::WbSelAlu;
        o_Ctrl.pcSel       = CpuPkg::PcSelNext;
        o_Ctrl.regWrEnable = 1'b0;
        o_Ctrl.memWrEnable = 1'b0;

        case (CpuPkg::Opcode'(i_Inst.r.opcode))
            CpuPkg::OpReg, CpuPkg::OpImm: begin
                if (i_Inst.r.opcode == CpuPkg::OpImm)
                    o_Ctrl.operandBSel = CpuPkg::OpBSelImm;
                o_Ctrl.regWrEnable = 1'b1;
                case (funct3)
                    3'b000: begin // No SUBI, so funct7 only counts for OpReg
                        if (isAlt && i_Inst.r.opcode == CpuPkg::OpReg)
                            o_Ctrl.aluOp = CpuPkg::AluSub;
                    end
                    3'b111:  o_Ctrl.aluOp = CpuPkg::AluAnd;
                    3'b110:  o_Ctrl.aluOp = CpuPkg::AluOr;
                    3'b100:  o_Ctrl.aluOp = CpuPkg::AluXor;
                    3'b010:  o_Ctrl.aluOp = CpuPkg::AluSlt;
                    3'b011:  o_Ctrl.aluOp = CpuPkg::AluSltu;
                    default: o_Ctrl.regWrEnable = 1'b0; // Shifts not built
                endcase
            end
            CpuPkg::OpLui: begin
                o_Ctrl.aluOp       = CpuPkg::AluPassB;
                o_Ctrl.operandBSel = CpuPkg::OpBSelImm;
                o_Ctrl.regWrEnable = 1'b1;
            end
            CpuPkg::OpLoad: begin
                o_Ctrl.operandBSel = CpuPkg::OpBSelImm; // rs1 + offset
                o_Ctrl.wbSel       = CpuPkg::WbSelMem;
                o_Ctrl.regWrEnable = (funct3 == 3'b010); // LW only
            end
            CpuPkg::OpStore: begin
                o_Ctrl.operandBSel = CpuPkg::OpBSelImm;
                o_Ctrl.memWrEnable = (funct3 == 3'b010); // SW only
            end
            CpuPkg::OpBranch: begin
                if (taken)
                    o_Ctrl.pcSel = CpuPkg::PcSelBranch;
            end
            CpuPkg::OpJal: begin
                o_Ctrl.operandASel = CpuPkg::OpASelPc;
                o_Ctrl.operandBSel = CpuPkg::OpBSelImm;
                o_Ctrl.wbSel       = CpuPkg::WbSelPc4; // Link
                o_Ctrl.pcSel       = CpuPkg::PcSelBranch;
                o_Ctrl.regWrEnable = 1'b1;
            end
            CpuPkg::OpJalr: begin
                o_Ctrl.operandBSel = CpuPkg::OpBSelImm;
                o_Ctrl.wbSel       = CpuPkg::WbSelPc4;
                o_Ctrl.pcSel       = CpuPkg::PcSelJalr;
                o_Ctrl.regWrEnable = 1'b1;
            end
            default: o_Ctrl.operandASel = CpuPkg::OpASelZero; // Unknown opcode
        endcase
    end

endmodule

//--- rtl/RegisterFile.sv
`timescale 1ns/1ns

module RegisterFile (
    input  logic        i_Clock,
    input  logic        i_reset,
    input  logic        i_WrEnable,
    input  logic [4:0]  i_WrAddr,
    input  logic [4:0]  i_RdAddrA,
    input  logic [4:0]  i_RdAddrB,
    input  logic [31:0] i_WrData,
    output logic [31:0] o_RdDataA,
    output logic [31:0] o_RdDataB
);

    logic [31:0] regs [0:31]; // x0 entry only cleared by reset

    always_ff @(posedge i_Clock) begin
        if (i_reset)
            regs <= '{default: 32'd0};
        else if (i_WrEnable && i_WrAddr != 5'd0) // Drop writes to x0
            regs[i_WrAddr] <= i_WrData;
    end

    // Combinational reads
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

    // Write gating keeps x0 at zero
    assert property (@(posedge i_Clock) disable iff (i_reset) regs[0] == 32'd0)
        else $error("x0 holds a nonzero value");

endmodule

//--- rtl/IntegerALU.sv
`timescale 1ns/1ns

module IntegerALU (
    input  CpuPkg::AluOp i_Op,
    input  logic [31:0]  i_OperandA,
    input  logic [31:0]  i_OperandB,
    input  logic [31:0]  i_CmpA,     // Register value rs1
    input  logic [31:0]  i_CmpB,     // Register value rs2
    output logic [31:0]  o_Result,
    output logic         o_IsEq,
    output logic         o_IsLt,
    output logic         o_IsLtu
);

    // --------------------------------------
    // Arithmetic and logic
    // --------------------------------------
    always_comb begin
        case (i_Op)
            CpuPkg::AluAdd:   o_Result = i_OperandA + i_OperandB;
            CpuPkg::AluSub:   o_Result = i_OperandA - i_OperandB;
            CpuPkg::AluAnd:   o_Result = i_OperandA & i_OperandB;
            CpuPkg::AluOr:    o_Result = i_OperandA | i_OperandB;
            CpuPkg::AluXor:   o_Result = i_OperandA ^ i_OperandB;
            CpuPkg::AluSlt:   o_Result = {31'd0, $signed(i_OperandA) < $signed(i_OperandB)};
            CpuPkg::AluSltu:  o_Result = {31'd0, i_OperandA < i_OperandB};
            CpuPkg::AluPassB: o_Result = i_OperandB; // LUI
            default:          o_Result = 32'd0;
        endcase
    end

    // --------------------------------------
    // Branch comparer
    // --------------------------------------
    assign o_IsEq  = (i_CmpA == i_CmpB);
    assign o_IsLt  = $signed(i_CmpA) < $signed(i_CmpB);
    assign o_IsLtu = i_CmpA < i_CmpB;

endmodule

//--- rtl/ProcessorSC.sv
`timescale 1ns/1ns

module ProcessorSC (
    input  logic              i_Clock,
    input  logic              i_reset,
    output logic [31:0]       o_InstAddr,  // Fetch address
    input  CpuPkg::Inst       i_Inst,      // Fetched word
    output CpuPkg::DataBusReq o_MemWr,     // Data bus request
    input  logic [31:0]       i_MemRdData  // Load data
);

    // --------------------------------------
    // Program counter
    // --------------------------------------
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] pcPlusImm;    // Branch and JAL target
    logic [31:0] rs1PlusImm;   // JALR target

    CpuPkg::DecodedInst  decoded;
    CpuPkg::DatapathCtrl ctrl;
    logic [31:0] rdDataA, rdDataB;
    logic [31:0] operandA, operandB;
    logic [31:0] aluResult;
    logic [31:0] wbData;
    logic        isEq, isLt, isLtu;

    assign pcPlus4    = pc + 32'd4;
    assign pcPlusImm  = pc + decoded.imm;
    assign rs1PlusImm = (rdDataA + decoded.imm) & ~32'd1; // Bit 0 cleared

    always_comb begin
        case (ctrl.pcSel)
            CpuPkg::PcSelBranch: pcNext = pcPlusImm;
            CpuPkg::PcSelJalr:   pcNext = rs1PlusImm;
            default:             pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (i_reset)
            pc <= 32'd0;
        else
            pc <= pcNext;
    end

    assign o_InstAddr = pc;

    // --------------------------------------
    // Decode and control
    // --------------------------------------
    InstDecoder dec (
        .i_Inst    (i_Inst),
        .o_Decoded (decoded));

    DatapathController dpCtrl (
        .i_Inst  (i_Inst),
        .i_IsEq  (isEq),
        .i_IsLt  (isLt),
        .i_IsLtu (isLtu),
        .o_Ctrl  (ctrl));

    RegisterFile regs (
        .i_Clock    (i_Clock),
        .i_reset    (i_reset),
        .i_WrEnable (ctrl.regWrEnable),
        .i_WrAddr   (decoded.rd),
        .i_RdAddrA  (decoded.rs1),
        .i_RdAddrB  (decoded.rs2),
        .i_WrData   (wbData),
        .o_RdDataA  (rdDataA),
        .o_RdDataB  (rdDataB));

    // --------------------------------------
    // Operand select and ALU
    // --------------------------------------
    always_comb begin
        case (ctrl.operandASel)
            CpuPkg::OpASelPc:   operandA = pc;
            CpuPkg::OpASelZero: operandA = 32'd0;
            default:            operandA = rdDataA;
        endcase
    end

    assign operandB = (ctrl.operandBSel == CpuPkg::OpBSelImm) ? decoded.imm : rdDataB;

    IntegerALU alu (
        .i_Op       (ctrl.aluOp),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .i_CmpA     (rdDataA),
        .i_CmpB     (rdDataB),
        .o_Result   (aluResult),
        .o_IsEq     (isEq),
        .o_IsLt     (isLt),
        .o_IsLtu    (isLtu));

    // Write-back select
    always_comb begin
        case (ctrl.wbSel)
            CpuPkg::WbSelMem: wbData = i_MemRdData;
            CpuPkg::WbSelPc4: wbData = pcPlus4; // Link value
            default:          wbData = aluResult;
        endcase
    end

    // Data bus drive
    assign o_MemWr.addr     = aluResult;
    assign o_MemWr.wrData   = rdDataB;
    assign o_MemWr.wrEnable = ctrl.memWrEnable && !i_reset; // Quiet while loading

    // Jump and branch targets keep fetch word aligned
    assert property (@(posedge i_Clock) disable iff (i_reset) pc[1:0] == 2'b00)
        else $error("PC misaligned");

endmodule

//--- rtl/ProgramMemory.sv
`timescale 1ns/1ns

module ProgramMemory #(
    parameter PROG_ADDR_BITS = 6
) (
    input  logic                      i_Clock,
    input  logic                      i_WrEnable, // Load port
    input  logic [PROG_ADDR_BITS-1:0] i_WrAddr,   // Word address
    input  logic [31:0]               i_WrData,
    input  logic [31:0]               i_Addr,     // Byte address from PC
    output CpuPkg::Inst               o_Inst
);

    logic [31:0] mem [2**PROG_ADDR_BITS];

    always_ff @(posedge i_Clock) begin
        if (i_WrEnable)
            mem[i_WrAddr] <= i_WrData;
    end

    // Upper PC bits dropped so fetch wraps
    assign o_Inst = mem[i_Addr[PROG_ADDR_BITS+1:2]];

endmodule

//--- rtl/DataMemory.sv
`timescale 1ns/1ns

module DataMemory #(
    parameter DATA_ADDR_BITS = 6
) (
    input  logic              i_Clock,
    input  CpuPkg::DataBusReq i_Req,
    output logic [31:0]       o_RdData
);

    logic [31:0]               mem [2**DATA_ADDR_BITS];
    logic [DATA_ADDR_BITS-1:0] wordAddr; // Byte offset dropped

    assign wordAddr = i_Req.addr[DATA_ADDR_BITS+1:2];

    // Clocked write
    always_ff @(posedge i_Clock) begin
        if (i_Req.wrEnable)
            mem[wordAddr] <= i_Req.wrData;
    end

    assign o_RdData = mem[wordAddr]; // Same cycle read

    // Only word stores exist
    assert property (@(posedge i_Clock) i_Req.wrEnable |-> i_Req.addr[1:0] == 2'b00)
        else $error("Misaligned store to %h", i_Req.addr);

endmodule

//--- rtl/ProcessorSystem.sv
`timescale 1ns/1ns

module ProcessorSystem #(
    parameter PROG_ADDR_BITS = 6,
    parameter DATA_ADDR_BITS = 6
) (
    input  logic                      i_Clock,
    input  logic                      i_reset,
    input  logic                      i_ProgWrEnable, // Program load, in reset only
    input  logic [PROG_ADDR_BITS-1:0] i_ProgWrAddr,
    input  logic [31:0]               i_ProgWrData,
    output CpuPkg::DataBusReq         o_MemWr         // Store observation
);

    logic [31:0]       instAddr;
    CpuPkg::Inst       inst;
    CpuPkg::DataBusReq memReq;
    logic [31:0]       memRdData;

    ProcessorSC cpu (
        .i_Clock     (i_Clock),
        .i_reset     (i_reset),
        .o_InstAddr  (instAddr),
        .i_Inst      (inst),
        .o_MemWr     (memReq),
        .i_MemRdData (memRdData));

    ProgramMemory #(
        .PROG_ADDR_BITS (PROG_ADDR_BITS))
    progMem (
        .i_Clock    (i_Clock),
        .i_WrEnable (i_ProgWrEnable),
        .i_WrAddr   (i_ProgWrAddr),
        .i_WrData   (i_ProgWrData),
        .i_Addr     (instAddr),
        .o_Inst     (inst));

    DataMemory #(
        .DATA_ADDR_BITS (DATA_ADDR_BITS))
    dataMem (
        .i_Clock  (i_Clock),
        .i_Req    (memReq),
        .o_RdData (memRdData));

    assign o_MemWr = memReq;

endmodule

//--- verification/ProcessorSystemTb.sv
`timescale 1ns/1ns

module ProcessorSystemTb;

    localparam int ProgAddrBits = 6;
    localparam int DataAddrBits = 6;
    localparam int MaxProg      = 16;          // Program words per test
    localparam int LoadCycles   = MaxProg + 4; // Reset, load and release
    localparam int StoreLimit   = 32;          // Cycles allowed per test

    // Major opcodes for the program builder
    localparam logic [6:0] OpRegCode  = 7'b0110011;
    localparam logic [6:0] OpImmCode  = 7'b0010011;
    localparam logic [6:0] OpLoadCode = 7'b0000011;
    localparam logic [6:0] OpJalrCode = 7'b1100111;

    typedef enum logic [4:0] {
        KAdd, KSub, KAnd, KOr, KXor, KSlt, KSltu,
        KAddi, KAndi, KOri, KXori, KSlti, KLui,
        KBeq, KBne, KBlt, KBge, KBltu, KBgeu,
        KJal, KJalr, KMem, KZero
    } TestKind;

    typedef struct packed {
        logic [47:0] name;  // Up to six characters
        TestKind     kind;
        logic [19:0] imm;   // Low 12 bits for I type, all 20 for LUI
        logic        randA; // Operand A from the generator
        logic [31:0] fixA;
        logic        randB;
        logic [31:0] fixB;
        logic [7:0]  addr;  // Byte address of the checked store
    } TestEntry;

    logic              clock;
    logic              reset;
    logic              progWrEnable;
    logic [5:0]        progWrAddr;
    logic [31:0]       progWrData;
    CpuPkg::DataBusReq memWr;

    TestEntry    tests [$];
    logic [31:0] prog [MaxProg];
    int          progLen;
    logic [31:0] testPc;          // PC of the jump under test
    logic [31:0] rngState = 32'd23;
    logic        tableReady = 1'b0;

    ProcessorSystem #(
        .PROG_ADDR_BITS (ProgAddrBits),
        .DATA_ADDR_BITS (DataAddrBits))
    i_dut (
        .i_Clock        (clock),
        .i_reset        (reset),
        .i_ProgWrEnable (progWrEnable),
        .i_ProgWrAddr   (progWrAddr),
        .i_ProgWrData   (progWrData),
        .o_MemWr        (memWr));

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3,
                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpRegCode};
    endfunction

    function logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                               input logic [2:0] f3, input logic [4:0] rd,
                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // SW
    endfunction

    function logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111}; // LUI
    endfunction

    function logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Upper part rounded so the signed ADDI low part lands exactly
    function logic [19:0] upperPart(input logic [31:0] v);
        logic [31:0] r;
        r = v + 32'h800;
        return r[31:12];
    endfunction

    function logic [2:0] funct3Of(input TestKind k);
        case (k)
            KAnd, KAndi, KBgeu: return 3'b111;
            KOr, KOri, KBltu:   return 3'b110;
            KXor, KXori, KBlt:  return 3'b100;
            KSlt, KSlti:        return 3'b010;
            KSltu:              return 3'b011;
            KBne:               return 3'b001;
            KBge:               return 3'b101;
            default:            return 3'b000;
        endcase
    endfunction

    function logic [7:0] storeAddr(input TestEntry t);
        return (t.kind == KMem) ? t.addr + 8'd4 : t.addr; // Second store is checked
    endfunction

    task addEntry(input logic [47:0] name, input TestKind kind, input logic [19:0] imm,
                  input logic randA, input logic [31:0] fixA,
                  input logic randB, input logic [31:0] fixB);
        TestEntry t;
        t = '{name, kind, imm, randA, fixA, randB, fixB, 8'(tests.size() * 8)};
        tests.push_back(t);
    endtask

    task emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // ----------------------------------------
    // Program builder and reference model
    // ----------------------------------------
    task buildProgram(input TestEntry t, input logic [31:0] a, input logic [31:0] b);
        logic [4:0] resultReg;
        logic [2:0] f3;
        resultReg = 5'd3;
        f3        = funct3Of(t.kind);
        progLen   = 0;
        testPc    = 32'd16;                                       // Word 4
        emit(encU(upperPart(a), 5'd1));                           // x1 = a
        emit(encI(a[11:0], 5'd1, 3'b000, 5'd1, OpImmCode));
        emit(encU(upperPart(b), 5'd2));                           // x2 = b
        emit(encI(b[11:0], 5'd2, 3'b000, 5'd2, OpImmCode));
        case (t.kind)
            KAdd, KAnd, KOr, KXor, KSlt, KSltu: emit(encR(7'h00, 5'd2, 5'd1, f3, 5'd3));
            KSub: emit(encR(7'h20, 5'd2, 5'd1, f3, 5'd3));
            KAddi, KAndi, KOri, KXori, KSlti:
                emit(encI(t.imm[11:0], 5'd1, f3, 5'd3, OpImmCode));
            KLui: emit(encU(t.imm, 5'd3));
            KBeq, KBne, KBlt, KBge, KBltu, KBgeu: begin
                emit(encI(12'd1, 5'd0, 3'b000, 5'd3, OpImmCode)); // Marker 1
                emit(encB(13'd8, 5'd2, 5'd1, f3));
                emit(encI(12'd2, 5'd0, 3'b000, 5'd3, OpImmCode)); // Marker 2 if not taken
            end
            KJal: begin
                emit(encJ(21'd8, 5'd3));
                emit(encI(12'd77, 5'd0, 3'b000, 5'd3, OpImmCode)); // Must be skipped
            end
            KJalr: begin
                emit(encI(12'd2, 5'd1, 3'b000, 5'd3, OpJalrCode)); // 23 + 2, bit 0 cleared
                emit(encI(12'd77, 5'd0, 3'b000, 5'd3, OpImmCode));
            end
            KMem: begin
                emit(encS({4'd0, t.addr}, 5'd1, 5'd0));
                emit(encI({4'd0, t.addr}, 5'd0, 3'b010, 5'd4, OpLoadCode)); // LW x4
                emit(encI(12'd1, 5'd4, 3'b000, 5'd3, OpImmCode));
            end
            default: begin                                         // x0 write attempt
                emit(encI(t.imm[11:0], 5'd0, 3'b000, 5'd0, OpImmCode));
                resultReg = 5'd0;
            end
        endcase
        emit(encS({4'd0, storeAddr(t)}, resultReg, 5'd0));
        emit(encJ(21'd0, 5'd0));                                   // Spin here
    endtask

    function logic [31:0] expectedData(input TestEntry t, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] jumpPc);
        logic [31:0] immS;
        logic        taken;
        immS  = {{20{t.imm[11]}}, t.imm[11:0]};
        taken = 1'b0;
        case (t.kind)
            KBeq:  taken = (a == b);
            KBne:  taken = (a != b);
            KBlt:  taken = ($signed(a) < $signed(b));
            KBge:  taken = ($signed(a) >= $signed(b));
            KBltu: taken = (a < b);
            KBgeu: taken = (a >= b);
            default: taken = 1'b0;
        endcase
        case (t.kind)
            KAdd:  return a + b;
            KSub:  return a - b;
            KAnd:  return a & b;
            KOr:   return a | b;
            KXor:  return a ^ b;
            KSlt:  return {31'd0, $signed(a) < $signed(b)};
            KSltu: return {31'd0, a < b};
            KAddi: return a + immS;
            KAndi: return a & immS;
            KOri:  return a | immS;
            KXori: return a ^ immS;
            KSlti: return {31'd0, $signed(a) < $signed(immS)};
            KLui:  return {t.imm, 12'd0};
            KBeq, KBne, KBlt, KBge, KBltu, KBgeu: return taken ? 32'd1 : 32'd2;
            KJal, KJalr: return jumpPc + 32'd4;                   // Link value
            KMem:  return a + 32'd1;
            default: return 32'd0;
        endcase
    endfunction

    // ----------------------------------------
    // Bus driving and observation
    // ----------------------------------------
    task loadAndRun();
        @(posedge clock);
        reset        <= 1'b1;
        progWrEnable <= 1'b0;
        repeat (2) @(posedge clock);
        for (int w = 0; w < progLen; w++) begin
            @(posedge clock);
            progWrEnable <= 1'b1;
            progWrAddr   <= 6'(w);
            progWrData   <= prog[w];
        end
        @(posedge clock);                  // Last word written here
        progWrEnable <= 1'b0;
        reset        <= 1'b0;
    endtask

    task waitForStore(input int needed, output logic seen, output CpuPkg::DataBusReq req);
        int stores;
        int cycles;
        stores = 0;
        cycles = 0;
        seen   = 1'b0;
        req    = '0;
        while (!seen && cycles < StoreLimit) begin
            @(posedge clock);
            cycles++;
            if (memWr.wrEnable) begin
                stores++;
                if (stores == needed) begin
                    seen = 1'b1;
                    req  = memWr;          // Values of the cycle just ending
                end
            end
        end
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin
        wait (tableReady);
        #(tests.size() * (LoadCycles + 34) * 10);
        $display("Watchdog expired before all tests finished");
        $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        TestEntry          t;
        logic [31:0]       a, b;
        logic [31:0]       expData, expAddr;
        logic              seen, ok;
        CpuPkg::DataBusReq req;
        int                passCount, failCount;
        reset        = 1'b1;
        progWrEnable = 1'b0;
        progWrAddr   = '0;
        progWrData   = '0;
        passCount    = 0;
        failCount    = 0;

        addEntry("ADD",    KAdd,  20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("ADD_E",  KAdd,  20'h0, 1'b0, 32'h7fffffff, 1'b0, 32'h1);
        addEntry("SUB",    KSub,  20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("SUB_E",  KSub,  20'h0, 1'b0, 32'h0,        1'b0, 32'h1);
        addEntry("AND",    KAnd,  20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("OR",     KOr,   20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("XOR",    KXor,  20'h0, 1'b1, 32'h0,        1'b0, 32'hffffffff);
        addEntry("SLT_E",  KSlt,  20'h0, 1'b0, 32'h80000000, 1'b0, 32'h1);
        addEntry("SLT",    KSlt,  20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("SLTU_E", KSltu, 20'h0, 1'b0, 32'h80000000, 1'b0, 32'h1);
        addEntry("SLTU",   KSltu, 20'h0, 1'b1, 32'h0,        1'b1, 32'h0);
        addEntry("ADDI",   KAddi, 20'h800, 1'b1, 32'h0,      1'b0, 32'h0);
        addEntry("ADDI_E", KAddi, 20'hfff, 1'b0, 32'h5,      1'b0, 32'h0);
        addEntry("ANDI",   KAndi, 20'hf0f, 1'b1, 32'h0,      1'b0, 32'h0);
        addEntry("ORI",    KOri,  20'h800, 1'b1, 32'h0,      1'b0, 32'h0);
        addEntry("XORI",   KXori, 20'hfff, 1'b1, 32'h0,      1'b0, 32'h0);
        addEntry("SLTI",   KSlti, 20'hfff, 1'b0, 32'h5,      1'b0, 32'h0);
        addEntry("LUI",    KLui,  20'hfffff, 1'b0, 32'h0,    1'b0, 32'h0);
        addEntry("LUI_2",  KLui,  20'h80001, 1'b0, 32'h0,    1'b0, 32'h0);
        addEntry("BEQ_T",  KBeq,  20'h0, 1'b0, 32'h5,        1'b0, 32'h5);
        addEntry("BEQ_N",  KBeq,  20'h0, 1'b0, 32'h5,        1'b0, 32'h6);
        addEntry("BNE_T",  KBne,  20'h0, 1'b0, 32'h5,        1'b0, 32'h6);
        addEntry("BNE_N",  KBne,  20'h0, 1'b0, 32'h5,        1'b0, 32'h5);
        addEntry("BLT_T",  KBlt,  20'h0, 1'b0, 32'hffffffff, 1'b0, 32'h1);
        addEntry("BLT_N",  KBlt,  20'h0, 1'b0, 32'h1,        1'b0, 32'hffffffff);
        addEntry("BLTU_N", KBltu, 20'h0, 1'b0, 32'hffffffff, 1'b0, 32'h1);
        addEntry("BLTU_T", KBltu, 20'h0, 1'b0, 32'h1,        1'b0, 32'hffffffff);
        addEntry("BGE_T",  KBge,  20'h0, 1'b0, 32'h1,        1'b0, 32'hffffffff);
        addEntry("BGE_EQ", KBge,  20'h0, 1'b0, 32'h7,        1'b0, 32'h7);
        addEntry("BGEU_N", KBgeu, 20'h0, 1'b0, 32'h1,        1'b0, 32'hffffffff);
        addEntry("BGEU_T", KBgeu, 20'h0, 1'b0, 32'hffffffff, 1'b0, 32'h1);
        addEntry("JAL",    KJal,  20'h0, 1'b0, 32'h0,        1'b0, 32'h0);
        addEntry("JALR",   KJalr, 20'h0, 1'b0, 32'h0,        1'b0, 32'h0);
        addEntry("MEM_RT", KMem,  20'h0, 1'b1, 32'h0,        1'b0, 32'h0);
        addEntry("X0",     KZero, 20'h123, 1'b0, 32'h0,      1'b0, 32'h0);
        tableReady = 1'b1;

        foreach (tests[i]) begin
            t  = tests[i];
            a  = t.randA ? nextRandom() : t.fixA;
            b  = t.randB ? nextRandom() : t.fixB;
            if (t.kind == KJalr)
                a = 32'd23;                        // JALR word + 7
            buildProgram(t, a, b);
            expData = expectedData(t, a, b, testPc);
            expAddr = {24'd0, storeAddr(t)};
            loadAndRun();
            waitForStore((t.kind == KMem) ? 2 : 1, seen, req);
            ok = 1'b1;
            if (!seen) begin
                $display("%s: no store seen within %0d cycles", t.name, StoreLimit);
                ok = 1'b0;
            end else begin
                if (req.addr !== expAddr) begin
                    $display("CHECK FAILED t=%0t o_MemWr.addr expected %h actual %h",
                             $time, expAddr, req.addr);
                    ok = 1'b0;
                end
                if (req.wrData !== expData) begin
                    $display("CHECK FAILED t=%0t o_MemWr.wrData expected %h actual %h",
                             $time, expData, req.wrData);
                    ok = 1'b0;
                end
            end
            if (ok)
                passCount++;
            else
                failCount++;
            $display("%s: %s", t.name, ok ? "pass" : "fail");
        end

        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- compile.f
rtl/CpuPkg.sv
rtl/InstDecoder.sv
rtl/DatapathController.sv
rtl/RegisterFile.sv
rtl/IntegerALU.sv
rtl/ProcessorSC.sv
rtl/ProgramMemory.sv
rtl/DataMemory.sv
rtl/ProcessorSystem.sv
verification/ProcessorSystemTb.sv
